// File: common/boot_ram_pkg.sv
// boot RAM geometry; port width must divide the line width and both must be whole bytes
`default_nettype none

package boot_ram_pkg;

   //////////////////////////////////////////////////
   // memory size and line shape
   //////////////////////////////////////////////////

   localparam int bram_size_bits  = 16;                     // 2^16 bytes, 64 KB
   localparam int bram_line_width = 128;                    // one storage line
   localparam int line_strb_width = bram_line_width / 8;    // bytes per line
   localparam int bram_lines      = (2 ** bram_size_bits) / line_strb_width;

   //////////////////////////////////////////////////
   // access port
   //////////////////////////////////////////////////

   localparam int port_data_width = 64;
   localparam int port_strb_width = port_data_width / 8;    // byte enables per word
   localparam int lanes_per_line  = bram_line_width / port_data_width;

   // byte address layout: line | lane | offset
   localparam int offset_bits    = $clog2(port_strb_width);
   localparam int lane_bits      = $clog2(lanes_per_line);
   localparam int line_addr_bits = bram_size_bits - lane_bits - offset_bits;
   localparam int port_addr_bits = bram_size_bits;

endpackage

`default_nettype wire

// File: common/boot_cfg_pkg.sv
// boot source encoding and reset vectors; vector values are fixed by the SoC address map
`default_nettype none

package boot_cfg_pkg;

   //////////////////////////////////////////////////
   // boot source
   //////////////////////////////////////////////////

   typedef enum logic [1:0]
   {
      boot_bram,            // on-chip boot memory
      boot_dram,            // start of DRAM
      boot_dram_offset      // DRAM past the loader area
   } boot_source_e;

   //////////////////////////////////////////////////
   // reset vectors
   //////////////////////////////////////////////////

   localparam int reset_vector_width = 32;

   // boot_sel bit 0 low
   localparam logic [reset_vector_width-1:0] bram_reset_vector =
      32'h4000_0000;

   // boot_sel 01
   localparam logic [reset_vector_width-1:0] dram_reset_vector =
      32'h8000_0000;

   // boot_sel 11
   localparam logic [reset_vector_width-1:0] dram_offset_reset_vector =
      32'h8020_0000;

endpackage

`default_nettype wire

// File: boot_ram/boot_ram_lane.sv
// port side of the boot RAM; address bits below the word offset are ignored, no reset on lane state
`default_nettype none
`timescale 1ns/1ps

module boot_ram_lane
   import boot_ram_pkg::*;
(
   input  logic                       ram_clk,
   input  logic                       ram_en,
   input  logic [port_strb_width-1:0] ram_we,
   input  logic [port_addr_bits-1:0]  ram_addr,
   input  logic [port_data_width-1:0] ram_wrdata,
   input  logic [bram_line_width-1:0] line_rddata,
   output logic [line_addr_bits-1:0]  line_wr_addr,
   output logic [line_strb_width-1:0] line_we,
   output logic [bram_line_width-1:0] line_wrdata,
   output logic [line_addr_bits-1:0]  line_rd_addr,
   output logic [port_data_width-1:0] ram_rddata
);

   logic [lane_bits-1:0] lane_sel;   // lane of the current request
   logic [lane_bits-1:0] lane_q;     // lane of the last enabled request

   //////////////////////////////////////////////////
   // request side
   //////////////////////////////////////////////////

   assign line_wr_addr = ram_addr[port_addr_bits-1 -: line_addr_bits];
   assign lane_sel     = ram_addr[offset_bits +: lane_bits];

   // same word on every lane, enables pick the half that lands
   assign line_wrdata = {lanes_per_line{ram_wrdata}};

   always_comb
   begin
      line_we = '0;
      if (ram_en)
      begin
         line_we[lane_sel*port_strb_width +: port_strb_width] = ram_we;
      end
   end

   //////////////////////////////////////////////////
   // read side
   //////////////////////////////////////////////////

   // held while idle so the last word stays on ram_rddata
   always_ff @(posedge ram_clk)
   begin
      if (ram_en)
      begin
         line_rd_addr <= line_wr_addr;
         lane_q       <= lane_sel;
      end
   end

   assign ram_rddata = line_rddata[lane_q*port_data_width +: port_data_width];   // lane select

endmodule

`default_nettype wire

// File: boot_ram/boot_ram_array.sv
// line storage of the boot RAM; content is undefined until written, no power-up image
`default_nettype none
`timescale 1ns/1ps

module boot_ram_array
   import boot_ram_pkg::*;
(
   input  logic                       ram_clk,
   input  logic [line_addr_bits-1:0]  line_wr_addr,
   input  logic [line_strb_width-1:0] line_we,
   input  logic [bram_line_width-1:0] line_wrdata,
   input  logic [line_addr_bits-1:0]  line_rd_addr,
   output logic [bram_line_width-1:0] line_rddata
);

   logic [bram_line_width-1:0] mem [0:bram_lines-1];

   //////////////////////////////////////////////////
   // byte write
   //////////////////////////////////////////////////

   // enables already carry ram_en, idle cycles write nothing
   always_ff @(posedge ram_clk)
   begin
      for (int i = 0; i < line_strb_width; i++)
      begin
         if (line_we[i])
         begin
            mem[line_wr_addr][i*8 +: 8] <= line_wrdata[i*8 +: 8];
         end
      end
   end

   //////////////////////////////////////////////////
   // read
   //////////////////////////////////////////////////

   // read address is already a register in the lane block, so a write
   // on the same edge shows up here together with the new address
   assign line_rddata = mem[line_rd_addr];   // write-first

endmodule

`default_nettype wire

// File: hw/boot_config.sv
// boot switch register; boot_sel is assumed stable, no synchronizer for a live DIP change
`default_nettype none
`timescale 1ns/1ps

module boot_config
   import boot_cfg_pkg::*;
(
   input  logic                          ram_clk,
   input  logic                          reset,
   input  logic [1:0]                    boot_sel,
   output logic [reset_vector_width-1:0] reset_vector
);

   boot_source_e boot_src_d;   // decoded switches
   boot_source_e boot_src_q;   // sampled source

   always_comb
   begin
      casez (boot_sel)
         2'b?0:   boot_src_d = boot_bram;
         2'b01:   boot_src_d = boot_dram;
         default: boot_src_d = boot_dram_offset;   // 11
      endcase
   end

   always_ff @(posedge ram_clk)
   begin
      if (reset)
      begin
         boot_src_q <= boot_bram;   // processor starts from boot RAM
      end
      else
      begin
         boot_src_q <= boot_src_d;
      end
   end

   always_comb
   begin
      case (boot_src_q)
         boot_dram:        reset_vector = dram_reset_vector;
         boot_dram_offset: reset_vector = dram_offset_reset_vector;
         default:          reset_vector = bram_reset_vector;
      endcase
   end

endmodule

`default_nettype wire

// File: hw/boot_ram_top.sv
// boot RAM with boot vector select; single clock, no back-pressure, read data one cycle late
`default_nettype none
`timescale 1ns/1ps

module boot_ram_top
   import boot_ram_pkg::*;
   import boot_cfg_pkg::*;
(
   input  logic                          ram_clk,
   input  logic                          reset,
   input  logic                          ram_en,
   input  logic [port_strb_width-1:0]    ram_we,
   input  logic [port_addr_bits-1:0]     ram_addr,
   input  logic [port_data_width-1:0]    ram_wrdata,
   input  logic [1:0]                    boot_sel,
   output logic [port_data_width-1:0]    ram_rddata,
   output logic [reset_vector_width-1:0] reset_vector
);

   //////////////////////////////////////////////////
   // line side of the memory
   //////////////////////////////////////////////////

   logic [line_addr_bits-1:0]  line_wr_addr;
   logic [line_strb_width-1:0] line_we;
   logic [bram_line_width-1:0] line_wrdata;
   logic [line_addr_bits-1:0]  line_rd_addr;
   logic [bram_line_width-1:0] line_rddata;

   boot_ram_lane lane0
   (
      .ram_clk      ( ram_clk      ),
      .ram_en       ( ram_en       ),
      .ram_we       ( ram_we       ),
      .ram_addr     ( ram_addr     ),
      .ram_wrdata   ( ram_wrdata   ),
      .line_rddata  ( line_rddata  ),
      .line_wr_addr ( line_wr_addr ),
      .line_we      ( line_we      ),
      .line_wrdata  ( line_wrdata  ),
      .line_rd_addr ( line_rd_addr ),
      .ram_rddata   ( ram_rddata   )
   );

   boot_ram_array array0
   (
      .ram_clk      ( ram_clk      ),
      .line_wr_addr ( line_wr_addr ),
      .line_we      ( line_we      ),
      .line_wrdata  ( line_wrdata  ),
      .line_rd_addr ( line_rd_addr ),
      .line_rddata  ( line_rddata  )
   );

   //////////////////////////////////////////////////
   // boot vector, independent of the memory path
   //////////////////////////////////////////////////

   boot_config cfg0
   (
      .ram_clk      ( ram_clk      ),
      .reset        ( reset        ),
      .boot_sel     ( boot_sel     ),
      .reset_vector ( reset_vector )
   );

endmodule

`default_nettype wire

// File: verif/boot_ram_assert.sv
// shadow checker for the boot RAM; only words that got one full write are compared on reads
`default_nettype none
`timescale 1ns/1ps

module boot_ram_assert
   import boot_ram_pkg::*;
   import boot_cfg_pkg::*;
(
   input logic                          ram_clk,
   input logic                          reset,
   input logic                          ram_en,
   input logic [port_strb_width-1:0]    ram_we,
   input logic [port_addr_bits-1:0]     ram_addr,
   input logic [port_data_width-1:0]    ram_wrdata,
   input logic [1:0]                    boot_sel,
   input logic [port_data_width-1:0]    ram_rddata,
   input logic [reset_vector_width-1:0] reset_vector
);

   localparam int words     = (2 ** bram_size_bits) / port_strb_width;
   localparam int word_bits = port_addr_bits - offset_bits;

   int fail_count = 0;   // read by the testbench

   logic [7:0]                 shadow [0:(2 ** bram_size_bits)-1];
   logic                       written [0:words-1];   // set by a full-word write
   logic [word_bits-1:0]       word;
   logic [word_bits-1:0]       last_word;
   logic                       last_valid = 1'b0;
   logic [port_data_width-1:0] exp_word;

   assign word = ram_addr[port_addr_bits-1:offset_bits];   // offset bits ignored

   initial
   begin
      for (int i = 0; i < words; i++)
      begin
         written[i] = 1'b0;
      end
   end

   //////////////////////////////////////////////////
   // shadow memory
   //////////////////////////////////////////////////

   always @(posedge ram_clk)
   begin
      if (ram_en)
      begin
         for (int i = 0; i < port_strb_width; i++)
         begin
            if (ram_we[i])
            begin
               shadow[word*port_strb_width + i] <= ram_wrdata[i*8 +: 8];
            end
         end
         if (ram_we == '1)
         begin
            written[word] <= 1'b1;
         end
         last_word  <= word;
         last_valid <= written[word] || (ram_we == '1);   // write-first
      end
   end

   always_comb
   begin
      for (int i = 0; i < port_strb_width; i++)
      begin
         exp_word[i*8 +: 8] = shadow[last_word*port_strb_width + i];
      end
   end

   // bit 0 low boots from RAM, 01 from DRAM, 11 from DRAM past the loader
   function automatic logic [31:0] switch_vector(input logic [1:0] sel);
      if (!sel[0])
         return 32'h4000_0000;
      else if (!sel[1])
         return 32'h8000_0000;
      else
         return 32'h8020_0000;
   endfunction

   //////////////////////////////////////////////////
   // assertions
   //////////////////////////////////////////////////

   read_data_ok: assert property (@(posedge ram_clk) disable iff (reset)
      last_valid |-> (ram_rddata == exp_word))
   else
   begin
      fail_count = fail_count + 1;
      $error("read data %h differs from shadow %h", ram_rddata, exp_word);
   end

   vector_in_reset: assert property (@(posedge ram_clk)
      $past(reset) |-> (reset_vector == 32'h4000_0000))
   else
   begin
      fail_count = fail_count + 1;
      $error("reset vector %h is not the boot RAM vector after reset", reset_vector);
   end

   vector_follows_switches: assert property (@(posedge ram_clk) disable iff (reset)
      !$past(reset) |-> (reset_vector == switch_vector($past(boot_sel))))
   else
   begin
      fail_count = fail_count + 1;
      $error("reset vector %h does not match the switch setting", reset_vector);
   end

endmodule

`default_nettype wire

// File: verif/boot_ram_tb.sv
// testbench for the boot RAM top; bound assertions do the checking, this only drives and reports
`default_nettype none
`timescale 1ns/1ps

module boot_ram_tb
   import boot_ram_pkg::*;
   import boot_cfg_pkg::*;
();

   logic                          ram_clk = 1'b0;
   logic                          reset;
   logic                          ram_en;
   logic [port_strb_width-1:0]    ram_we;
   logic [port_addr_bits-1:0]     ram_addr;
   logic [port_data_width-1:0]    ram_wrdata;
   logic [1:0]                    boot_sel;
   logic [port_data_width-1:0]    ram_rddata;
   logic [reset_vector_width-1:0] reset_vector;

   logic [port_addr_bits-1:0] pool [$];   // fully written word addresses
   logic [1:0] sel_order [4] = '{2'b01, 2'b11, 2'b00, 2'b10};
   int tests_run       = 0;
   int tests_failed    = 0;
   int timeouts        = 0;
   int fails_before    = 0;
   int timeouts_before = 0;

   always #2 ram_clk = ~ram_clk;   // 4 ns period

   boot_ram_top dut0
   (
      .ram_clk      ( ram_clk      ),
      .reset        ( reset        ),
      .ram_en       ( ram_en       ),
      .ram_we       ( ram_we       ),
      .ram_addr     ( ram_addr     ),
      .ram_wrdata   ( ram_wrdata   ),
      .boot_sel     ( boot_sel     ),
      .ram_rddata   ( ram_rddata   ),
      .reset_vector ( reset_vector )
   );

   bind boot_ram_top boot_ram_assert assert0
   (
      .ram_clk      ( ram_clk      ),
      .reset        ( reset        ),
      .ram_en       ( ram_en       ),
      .ram_we       ( ram_we       ),
      .ram_addr     ( ram_addr     ),
      .ram_wrdata   ( ram_wrdata   ),
      .boot_sel     ( boot_sel     ),
      .ram_rddata   ( ram_rddata   ),
      .reset_vector ( reset_vector )
   );

   //////////////////////////////////////////////////
   // stimulus helpers
   //////////////////////////////////////////////////

   task automatic drive_access(input logic [port_addr_bits-1:0] addr,
                               input logic [port_strb_width-1:0] we,
                               input logic [port_data_width-1:0] data);
      @(posedge ram_clk);
      ram_en     <= 1'b1;
      ram_we     <= we;   // zero for a read
      ram_addr   <= addr;
      ram_wrdata <= data;
   endtask

   task automatic drive_idle(input int cycles);
      for (int i = 0; i < cycles; i++)
      begin
         @(posedge ram_clk);
         ram_en <= 1'b0;
         ram_we <= '0;
      end
   endtask

   function automatic logic [port_data_width-1:0] random_word();
      return {$urandom, $urandom};
   endfunction

   // lane 0 of a random line, with junk in the ignored offset bits
   function automatic logic [port_addr_bits-1:0] random_line_addr();
      return (16'($urandom) & 16'hfff0) | 16'($urandom_range(0, 7));
   endfunction

   function automatic logic [port_addr_bits-1:0] pick_written();
      return pool[$urandom_range(0, pool.size() - 1)];
   endfunction

   function automatic logic [31:0] expected_vector(input logic [1:0] sel);
      if (!sel[0])
         return 32'h4000_0000;
      else if (sel[1])
         return 32'h8020_0000;
      else
         return 32'h8000_0000;
   endfunction

   //////////////////////////////////////////////////
   // waits and reporting
   //////////////////////////////////////////////////

   task automatic wait_vector(input logic [31:0] expected);
      int n;
      n = 0;
      @(negedge ram_clk);
      while (reset_vector !== expected && n < 16)
      begin
         @(negedge ram_clk);
         n++;
      end
      if (reset_vector !== expected)
      begin
         timeouts++;
         $display("timed out after %0d cycles waiting for reset_vector %h", n, expected);
      end
   endtask

   task automatic wait_rddata_known();
      int n;
      n = 0;
      @(negedge ram_clk);
      while ($isunknown(ram_rddata) && n < 16)
      begin
         @(negedge ram_clk);
         n++;
      end
      if ($isunknown(ram_rddata))
      begin
         timeouts++;
         $display("timed out after %0d cycles waiting for read data to settle", n);
      end
   endtask

   task automatic finish_test(input string name);
      int errs;
      int tmo;
      @(negedge ram_clk);
      errs = dut0.assert0.fail_count - fails_before;
      tmo  = timeouts - timeouts_before;
      tests_run++;
      if (errs != 0 || tmo != 0)
      begin
         tests_failed++;
         $display("Fail at %0t: %s, %0d assertion failures, %0d timeouts",
                  $time, name, errs, tmo);
      end
      else
      begin
         $display("ok at %0t: %s", $time, name);
      end
      fails_before    = dut0.assert0.fail_count;
      timeouts_before = timeouts;
   endtask

   //////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////

   initial
   begin
      logic [port_addr_bits-1:0] a;
      void'($urandom(8));
      reset      = 1'b1;
      ram_en     = 1'b0;
      ram_we     = '0;
      ram_addr   = '0;
      ram_wrdata = '0;
      boot_sel   = 2'b11;   // reset must override the switches
      repeat (10) @(posedge ram_clk);
      reset <= 1'b0;

      // boot vector for every switch setting
      wait_vector(32'h4000_0000);
      for (int s = 0; s < 4; s++)
      begin
         @(posedge ram_clk);
         boot_sel <= sel_order[s];
         wait_vector(expected_vector(sel_order[s]));
      end
      finish_test("boot vector select");

      // both lanes of a line written in full, then read back
      for (int i = 0; i < 8; i++)
      begin
         a = random_line_addr();
         drive_access(a, '1, random_word());
         drive_access(a | 16'h8, '1, random_word());
         pool.push_back(a);
         pool.push_back(a | 16'h8);
         drive_access(a, '0, '0);
         drive_access(a | 16'h8, '0, '0);
      end
      drive_idle(1);
      wait_rddata_known();
      finish_test("full line write and lane read");

      // partial enables merge into old data
      for (int i = 0; i < 24; i++)
      begin
         a = pick_written();
         drive_access(a, 8'($urandom), random_word());
         drive_idle($urandom_range(0, 2));
         drive_access(a, '0, '0);
      end
      drive_idle(2);
      finish_test("partial byte enable write");

      for (int i = 0; i < 32; i++)
      begin
         drive_access(pick_written(), '0, '0);   // one read per cycle
      end
      drive_idle(2);
      finish_test("back-to-back reads");

      drive_access(pick_written(), '0, '0);
      drive_idle(8);   // data must hold while idle
      finish_test("read data held while idle");

      $display("%0d tests, %0d failed, %0d assertion failures, %0d timeouts",
               tests_run, tests_failed, dut0.assert0.fail_count, timeouts);
      if (tests_failed == 0)
      begin
         $display("All tests passed!");
      end
      else
      begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
common/boot_ram_pkg.sv
common/boot_cfg_pkg.sv
boot_ram/boot_ram_lane.sv
boot_ram/boot_ram_array.sv
hw/boot_config.sv
hw/boot_ram_top.sv
verif/boot_ram_assert.sv
verif/boot_ram_tb.sv
